// ==== src/system_pkg.sv ====
package system_pkg;

    // ------------------------------
    // Wishbone bus widths
    // ------------------------------

    // Fixed 32 bit data path
    localparam int WB_DWIDTH = 32;
    // One select per byte lane
    localparam int WB_SWIDTH = WB_DWIDTH / 8;
    localparam int WB_AWIDTH = 32;

    typedef logic [WB_AWIDTH-1:0] wb_adr_t;
    typedef logic [WB_DWIDTH-1:0] wb_data_t;
    typedef logic [WB_SWIDTH-1:0] wb_sel_t;

    // ------------------------------
    // Boot memory and address map
    // ------------------------------

    // 8 KB of embedded SRAM as 32 bit words
    localparam int BOOT_MEM_WORDS = 2048;
    // Word index width
    localparam int BOOT_MEM_AWIDTH = 11;

    // Boot region start and size in bytes
    localparam wb_adr_t BOOT_MEM_BASE = 32'h0000_0000;
    localparam wb_adr_t BOOT_MEM_BYTES = 32'h0000_2000;

    // Upper address half of the UART block
    localparam logic [WB_AWIDTH/2-1:0] UART_BASE_HI = 16'h1600;
    // Lower address half of the UART transmit register
    localparam logic [WB_AWIDTH/2-1:0] UART_TX_OFFSET = 16'h001C;

    // ------------------------------
    // Reset delay
    // ------------------------------

    localparam int RST_CNT_WIDTH = 8;
    // Terminal count where the delayed reset releases
    localparam int RST_DLY_MAX = 255;

    // ------------------------------
    // Debug outputs
    // ------------------------------

    localparam int LED_WIDTH = 8;
    localparam int GP_WIDTH = 2;

    // Bus response FSM states
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } bus_state_e;

endpackage

// ==== src/reset_delay.sv ====
`timescale 1ns/10ps

module reset_delay
    import system_pkg::*;
(
    input  logic brd_clk,
    input  logic brd_rst,
    output logic o_sys_rst
);

    // Delay counter
    logic [RST_CNT_WIDTH-1:0] dly_cnt;
    logic                     cnt_done;

    // Terminal count reached
    assign cnt_done = (dly_cnt == RST_CNT_WIDTH'(RST_DLY_MAX));

    // ------------------------------
    // Counter and delayed reset
    // ------------------------------

    always_ff @(posedge brd_clk) begin
        if (!brd_rst) begin
            // Board reset holds everything at the start
            dly_cnt   <= '0;
            o_sys_rst <= 1'b1;
        end else begin
            if (!cnt_done) begin
                // Count up once per cycle
                dly_cnt <= dly_cnt + 1'b1;
            end else begin
                // Counter parks at the top and system reset drops
                o_sys_rst <= 1'b0;
            end
        end
    end

    // Release lands 256 edges after the board reset goes high
    // which gives the rest of the system a long clean reset

endmodule

// ==== src/boot_mem.sv ====
`timescale 1ns/10ps

module boot_mem
    import system_pkg::*;
(
    input  logic                       brd_clk,
    input  logic                       i_en,
    input  logic                       i_we,
    input  wb_sel_t                    i_sel,
    input  logic [BOOT_MEM_AWIDTH-1:0] i_addr,
    input  wb_data_t                   i_wdat,
    output wb_data_t                   o_rdat
);

    // ------------------------------
    // Storage array
    // ------------------------------

    // 8 KB as 32 bit words
    wb_data_t mem_array [BOOT_MEM_WORDS];

    // ------------------------------
    // Write port
    // ------------------------------

    // Only selected byte lanes are updated
    always_ff @(posedge brd_clk) begin
        if (i_en && i_we) begin
            for (int lane = 0; lane < WB_SWIDTH; lane++) begin
                if (i_sel[lane]) begin
                    mem_array[i_addr][lane*8 +: 8] <= i_wdat[lane*8 +: 8];
                end
            end
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // Registered read one cycle after enable
    // A write cycle returns the old word
    always_ff @(posedge brd_clk) begin
        if (i_en) begin
            o_rdat <= mem_array[i_addr];
        end
    end

    // Contents stay undefined until written

endmodule

// ==== src/wb_bus_fsm.sv ====
`timescale 1ns/10ps

module wb_bus_fsm
    import system_pkg::*;
(
    input  logic                       brd_clk,
    input  logic                       brd_rst,
    input  logic                       i_sys_rst,

    // Wishbone slave side
    input  wb_adr_t                    i_wb_adr,
    input  wb_sel_t                    i_wb_sel,
    input  logic                       i_wb_we,
    input  wb_data_t                   i_wb_dat,
    input  logic                       i_wb_cyc,
    input  logic                       i_wb_stb,
    output wb_data_t                   o_wb_dat,
    output logic                       o_wb_ack,
    output logic                       o_wb_err,

    // Boot memory port
    input  wb_data_t                   i_mem_rdat,
    output logic                       o_mem_en,
    output logic                       o_mem_we,
    output wb_sel_t                    o_mem_sel,
    output logic [BOOT_MEM_AWIDTH-1:0] o_mem_addr,
    output wb_data_t                   o_mem_wdat
);

    // Request decode
    logic       wb_req;
    wb_adr_t    adr_offset;
    logic       req_mapped;

    // FSM state and request flags
    bus_state_e state;
    logic       mapped_q;
    logic       read_q;

    // ------------------------------
    // Address decode
    // ------------------------------

    // Valid request needs both cycle and strobe
    assign wb_req = i_wb_cyc && i_wb_stb;

    // Offset into the boot region
    assign adr_offset = i_wb_adr - BOOT_MEM_BASE;

    // Wraps below the base so one compare covers both ends
    assign req_mapped = (adr_offset < BOOT_MEM_BYTES);

    // ------------------------------
    // Response FSM
    // ------------------------------

    always_ff @(posedge brd_clk) begin
        if (!brd_rst || i_sys_rst) begin
            // Requests are ignored until the delayed reset releases
            state    <= IDLE;
            mapped_q <= 1'b0;
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
            o_mem_en <= 1'b0;
            o_mem_we <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    o_wb_ack <= 1'b0;
                    o_wb_err <= 1'b0;
                    if (wb_req) begin
                        state    <= ACCESS;
                        mapped_q <= req_mapped;
                        // Memory only sees mapped accesses
                        o_mem_en <= req_mapped;
                        o_mem_we <= req_mapped && i_wb_we;
                    end
                end

                ACCESS: begin
                    // Memory op completes at this edge
                    state    <= RESPOND;
                    o_mem_en <= 1'b0;
                    o_mem_we <= 1'b0;
                    // Exactly one of ack or err
                    o_wb_ack <= mapped_q;
                    o_wb_err <= !mapped_q;
                end

                RESPOND: begin
                    // Single cycle response then back to idle
                    state    <= IDLE;
                    o_wb_ack <= 1'b0;
                    o_wb_err <= 1'b0;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // Request payload capture
    // ------------------------------

    always_ff @(posedge brd_clk) begin
        if (state == IDLE && wb_req) begin
            // Word index drops the byte offset bits
            o_mem_addr <= adr_offset[BOOT_MEM_AWIDTH+1:2];
            o_mem_sel  <= i_wb_sel;
            o_mem_wdat <= i_wb_dat;
            read_q     <= !i_wb_we;
        end
    end

    // Read word comes straight from the memory output register
    // and is shown only during a read ack
    assign o_wb_dat = (o_wb_ack && read_q) ? i_mem_rdat : '0;

endmodule

// ==== src/system.sv ====
`timescale 1ns/10ps

module system
    import system_pkg::*;
(
    input  logic                 brd_clk,
    input  logic                 brd_rst,

    // Wishbone master ports driven from outside
    input  wb_adr_t              i_wb_adr,
    input  wb_sel_t              i_wb_sel,
    input  logic                 i_wb_we,
    input  wb_data_t             i_wb_dat,
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    output wb_data_t             o_wb_dat,
    output logic                 o_wb_ack,
    output logic                 o_wb_err,

    // Status and debug
    output logic                 o_system_rdy,
    output logic [LED_WIDTH-1:0] o_led_bar,
    output logic [GP_WIDTH-1:0]  o_gp_output
);

    // Delayed system reset
    logic                       sys_rst;

    // Boot memory port
    logic                       mem_en;
    logic                       mem_we;
    wb_sel_t                    mem_sel;
    logic [BOOT_MEM_AWIDTH-1:0] mem_addr;
    wb_data_t                   mem_wdat;
    wb_data_t                   mem_rdat;

    // ------------------------------
    // Reset delay
    // ------------------------------

    reset_delay u_reset_delay (
        .brd_clk   ( brd_clk ),
        .brd_rst   ( brd_rst ),
        .o_sys_rst ( sys_rst )
    );

    // Ready once the delayed reset drops
    assign o_system_rdy = !sys_rst;

    // ------------------------------
    // Bus decode and response
    // ------------------------------

    wb_bus_fsm u_wb_bus_fsm (
        .brd_clk    ( brd_clk  ),
        .brd_rst    ( brd_rst  ),
        .i_sys_rst  ( sys_rst  ),
        .i_wb_adr   ( i_wb_adr ),
        .i_wb_sel   ( i_wb_sel ),
        .i_wb_we    ( i_wb_we  ),
        .i_wb_dat   ( i_wb_dat ),
        .i_wb_cyc   ( i_wb_cyc ),
        .i_wb_stb   ( i_wb_stb ),
        .o_wb_dat   ( o_wb_dat ),
        .o_wb_ack   ( o_wb_ack ),
        .o_wb_err   ( o_wb_err ),
        .i_mem_rdat ( mem_rdat ),
        .o_mem_en   ( mem_en   ),
        .o_mem_we   ( mem_we   ),
        .o_mem_sel  ( mem_sel  ),
        .o_mem_addr ( mem_addr ),
        .o_mem_wdat ( mem_wdat )
    );

    // ------------------------------
    // Boot SRAM
    // ------------------------------

    boot_mem u_boot_mem (
        .brd_clk ( brd_clk  ),
        .i_en    ( mem_en   ),
        .i_we    ( mem_we   ),
        .i_sel   ( mem_sel  ),
        .i_addr  ( mem_addr ),
        .i_wdat  ( mem_wdat ),
        .o_rdat  ( mem_rdat )
    );

    // ------------------------------
    // Debug decodes
    // ------------------------------

    // LEDs follow the low address byte
    assign o_led_bar = i_wb_adr[LED_WIDTH-1:0];

    // Flag for any access in the UART block
    assign o_gp_output[0] = (i_wb_adr[WB_AWIDTH-1:WB_AWIDTH/2] == UART_BASE_HI);

    // Flag for the transmit register offset
    assign o_gp_output[1] = (i_wb_adr[WB_AWIDTH/2-1:0] == UART_TX_OFFSET);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD = 10
) (
    output logic o_clk
);

    // Free running board clock, 20 ns period at the default
    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD) o_clk = ~o_clk;
        end
    end

endmodule

// ==== tests/system_assertions.sv ====
`timescale 1ns/10ps

module system_assertions
    import system_pkg::*;
(
    input logic                 brd_clk,
    input logic                 brd_rst,
    input wb_adr_t              i_wb_adr,
    input wb_sel_t              i_wb_sel,
    input logic                 i_wb_we,
    input wb_data_t             i_wb_dat,
    input logic                 i_wb_cyc,
    input logic                 i_wb_stb,
    input wb_data_t             o_wb_dat,
    input logic                 o_wb_ack,
    input logic                 o_wb_err,
    input logic                 o_system_rdy,
    input logic [LED_WIDTH-1:0] o_led_bar,
    input logic [GP_WIDTH-1:0]  o_gp_output
);

    // Reset tracking and expected bus phase
    logic       rst_seen = 1'b0;
    int         rel_cnt = 0;
    bus_state_e exp_state = IDLE;

    // Shadow of the boot SRAM, valid bit per byte lane
    wb_data_t                   shadow [BOOT_MEM_WORDS];
    logic [WB_SWIDTH-1:0]       shadow_vld [BOOT_MEM_WORDS];
    logic                       in_boot;
    logic [BOOT_MEM_AWIDTH-1:0] word_idx;
    wb_data_t                   exp_word;
    wb_data_t                   exp_mask;

    // Expected debug flags
    logic [GP_WIDTH-1:0]        exp_gp;

    // Failing assertions so far
    int fail_total = 0;

    // ------------------------------
    // Reference model
    // ------------------------------

    // 8 KB region is aligned, so the top address bits pick it
    assign in_boot = (i_wb_adr[WB_AWIDTH-1:13] == BOOT_MEM_BASE[WB_AWIDTH-1:13]);
    assign word_idx = i_wb_adr[12:2];

    // UART block at 0x1600_xxxx, transmit register at offset 0x001C
    assign exp_gp = {i_wb_adr[15:0] == 16'h001C, i_wb_adr[31:16] == 16'h1600};

    always_comb begin
        exp_word = shadow[word_idx];
        for (int lane = 0; lane < WB_SWIDTH; lane++) begin
            exp_mask[lane*8 +: 8] = {8{shadow_vld[word_idx][lane]}};
        end
    end

    // Cycles since board reset release, and the phase a request should be in
    always @(posedge brd_clk) begin
        if (!brd_rst) begin
            rst_seen  <= 1'b1;
            rel_cnt   <= 0;
            exp_state <= IDLE;
        end else begin
            // Saturates well past the reset delay
            if (rel_cnt < 1000) begin
                rel_cnt <= rel_cnt + 1;
            end
            case (exp_state)
                IDLE: begin
                    if (o_system_rdy && i_wb_cyc && i_wb_stb) begin
                        exp_state <= ACCESS;
                    end
                end
                ACCESS: begin
                    exp_state <= RESPOND;
                end
                default: begin
                    exp_state <= IDLE;
                end
            endcase
        end
    end

    // Acked writes land in the shadow, selected lanes only
    always_ff @(posedge brd_clk) begin
        if (!brd_rst) begin
            for (int w = 0; w < BOOT_MEM_WORDS; w++) begin
                shadow_vld[w] <= '0;
            end
        end else if (o_wb_ack && i_wb_we && in_boot) begin
            for (int lane = 0; lane < WB_SWIDTH; lane++) begin
                if (i_wb_sel[lane]) begin
                    shadow[word_idx][lane*8 +: 8] <= i_wb_dat[lane*8 +: 8];
                    shadow_vld[word_idx][lane]    <= 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------

    a_rdy_low: assert property (@(posedge brd_clk)
        (rst_seen && rel_cnt < RST_DLY_MAX) |-> !o_system_rdy)
        else begin
            fail_total = fail_total + 1;
            $error("CHECK FAILED o_system_rdy got %h expected 0", o_system_rdy);
        end

    a_rdy_high: assert property (@(posedge brd_clk)
        (rst_seen && rel_cnt >= RST_DLY_MAX + 2) |-> o_system_rdy)
        else begin
            fail_total = fail_total + 1;
            $error("CHECK FAILED o_system_rdy got %h expected 1", o_system_rdy);
        end

    // No response outside the expected response cycle
    a_quiet: assert property (@(posedge brd_clk)
        (rst_seen && exp_state != RESPOND) |-> (!o_wb_ack && !o_wb_err))
        else begin
            fail_total = fail_total + 1;
            $error("CHECK FAILED o_wb_ack %h o_wb_err %h expected 0 and 0",
                o_wb_ack, o_wb_err);
        end

    // Mapped gives ack, anything else err
    a_resp: assert property (@(posedge brd_clk)
        (exp_state == RESPOND) |-> (o_wb_ack == in_boot && o_wb_err == !in_boot))
        else begin
            fail_total = fail_total + 1;
            $error("CHECK FAILED o_wb_ack %h o_wb_err %h expected %h and %h address %h",
                o_wb_ack, o_wb_err, in_boot, !in_boot, i_wb_adr);
        end

    a_rdat: assert property (@(posedge brd_clk)
        (exp_state == RESPOND && o_wb_ack && !i_wb_we)
        |-> ((o_wb_dat ^ exp_word) & exp_mask) == '0)
        else begin
            fail_total = fail_total + 1;
            $error("CHECK FAILED o_wb_dat got %h expected %h mask %h",
                o_wb_dat, exp_word, exp_mask);
        end

    a_led: assert property (@(posedge brd_clk) o_led_bar == i_wb_adr[7:0])
        else begin
            fail_total = fail_total + 1;
            $error("CHECK FAILED o_led_bar got %h expected %h", o_led_bar, i_wb_adr[7:0]);
        end

    // Bit 1 is the transmit offset, bit 0 the UART block
    a_gp: assert property (@(posedge brd_clk) o_gp_output == exp_gp)
        else begin
            fail_total = fail_total + 1;
            $error("CHECK FAILED o_gp_output got %h expected %h address %h",
                o_gp_output, exp_gp, i_wb_adr);
        end

endmodule

bind system system_assertions chk0 (.*);

// ==== tests/system_tb.sv ====
`timescale 1ns/10ps

module system_tb
    import system_pkg::*;
();

    localparam int SEED      = 5;
    localparam int RESP_WAIT = 20;
    localparam int RDY_WAIT  = 300;
    localparam int NUM_WORDS = 24;

    logic                 brd_clk;
    logic                 brd_rst;
    wb_adr_t              wb_adr;
    wb_sel_t              wb_sel;
    logic                 wb_we;
    wb_data_t             wb_dat;
    logic                 wb_cyc;
    logic                 wb_stb;
    wb_data_t             rd_dat;
    logic                 wb_ack;
    logic                 wb_err;
    logic                 system_rdy;
    logic [LED_WIDTH-1:0] led_bar;
    logic [GP_WIDTH-1:0]  gp_output;

    // Boot region addresses written so far
    wb_adr_t boot_adrs[$];

    tb_clock #(.HALF_PERIOD(10)) clk0 (.o_clk(brd_clk));

    system dut0 (
        .brd_clk(brd_clk), .brd_rst(brd_rst),
        .i_wb_adr(wb_adr), .i_wb_sel(wb_sel), .i_wb_we(wb_we), .i_wb_dat(wb_dat),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb),
        .o_wb_dat(rd_dat), .o_wb_ack(wb_ack), .o_wb_err(wb_err),
        .o_system_rdy(system_rdy), .o_led_bar(led_bar), .o_gp_output(gp_output)
    );

    // Stop at the first failure from the bound checker
    always @(negedge brd_clk) begin
        if (dut0.chk0.fail_total != 0) begin
            $display("Errors found");
            $fatal(1, "Bound checker reported a failing assertion");
        end
    end

    // ------------------------------
    // Bus tasks
    // ------------------------------

    task automatic wait_ready();
        int n;
        n = 0;
        while (!system_rdy && n < RDY_WAIT) begin
            @(negedge brd_clk);
            n++;
        end
        if (!system_rdy) begin
            $display("System ready never rose after the board reset released");
            $display("Errors found");
            $fatal(1, "Wait limit reached");
        end
    endtask

    // Ack or err sampled mid cycle
    task automatic wait_response();
        int n;
        n = 0;
        while (!(wb_ack || wb_err) && n < RESP_WAIT) begin
            @(negedge brd_clk);
            n++;
        end
        if (!(wb_ack || wb_err)) begin
            $display("No ack or err for the request at address %h", wb_adr);
            $display("Errors found");
            $fatal(1, "Wait limit reached");
        end
    endtask

    // Strobe drops in the cycle after the response
    task automatic end_access();
        @(posedge brd_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_access(input wb_adr_t adr, input wb_sel_t sel, input logic we,
                              input wb_data_t dat);
        @(posedge brd_clk);
        wb_adr <= adr;
        wb_sel <= sel;
        wb_we  <= we;
        wb_dat <= dat;
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wait_response();
        end_access();
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        wb_adr_t adr;
        void'($urandom(SEED));
        // UART transmit read held pending through the whole reset
        brd_rst = 1'b0;
        wb_adr  = {UART_BASE_HI, UART_TX_OFFSET};
        wb_sel  = '1;
        wb_we   = 1'b0;
        wb_dat  = '0;
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        repeat (2) @(posedge brd_clk);
        brd_rst <= 1'b1;
        wait_ready();
        wait_response();
        end_access();

        // Full word writes, top word of the region first
        boot_adrs.push_back(BOOT_MEM_BASE + BOOT_MEM_BYTES - 4);
        for (int i = 0; i < NUM_WORDS; i++) begin
            boot_adrs.push_back(BOOT_MEM_BASE + {19'd0, 11'($urandom), 2'b00});
        end
        foreach (boot_adrs[i]) bus_access(boot_adrs[i], '1, 1'b1, $urandom);

        // Partial writes with random lanes
        foreach (boot_adrs[i]) bus_access(boot_adrs[i], 4'($urandom), 1'b1, $urandom);

        // Unmapped writes that alias boot words, then random ones
        for (int i = 0; i < 8; i++) begin
            bus_access(boot_adrs[i] | 32'h4000_0000, '1, 1'b1, $urandom);
            adr = $urandom | 32'h0001_0000;
            bus_access(adr, 4'($urandom), 1'b1, $urandom);
        end
        bus_access(BOOT_MEM_BASE + BOOT_MEM_BYTES, '1, 1'b0, '0);
        bus_access({UART_BASE_HI, 16'h0040}, '1, 1'b1, $urandom);
        bus_access({16'h2000, UART_TX_OFFSET}, '1, 1'b0, '0);

        // Read everything back against the shadow
        foreach (boot_adrs[i]) bus_access(boot_adrs[i], 4'($urandom), 1'b0, '0);

        repeat (3) @(posedge brd_clk);
        @(negedge brd_clk);
        if (dut0.chk0.fail_total == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "Bound checker reported failing assertions");
        end
    end

endmodule

// ==== system.f ====
src/system_pkg.sv
src/reset_delay.sv
src/boot_mem.sv
src/wb_bus_fsm.sv
src/system.sv
tests/tb_clock.sv
tests/system_assertions.sv
tests/system_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       := system_tb
FILELIST  := system.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+100
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1); \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
